/* build.f */
rtl/uart_pkg.sv
rtl/fifo_if.sv
rtl/fifo.sv
rtl/baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_top.sv
bench/uart_tb.sv

/* Bender.yml */
package:
  name: uart

sources:
  - rtl/uart_pkg.sv
  - rtl/fifo_if.sv
  - rtl/fifo.sv
  - rtl/baud_gen.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/uart_top.sv
  - target: test
    files:
      - bench/uart_tb.sv

/* bench/uart_tb.sv */
/* testbench for the byte-wide serial port
   loops tx back to rx and checks ordering, flow control, overflow and glitch rejection */
module uart_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import uart_pkg::*;

   localparam int baud_div     = 4;
   localparam int adr_width    = 4;
   localparam int depth        = 1 << adr_width;
   localparam int clk_period   = 8;
   localparam int bit_cycles   = 16 * baud_div;
   localparam int frame_cycles = 10 * bit_cycles;
   localparam int bytes_sent   = 53;  // write attempts over all tests
   localparam longint watchdog_ns = 40 * bytes_sent * frame_cycles * clk_period + 100_000;

   logic  clk = 1'b0;
   logic  reset;
   logic  wr;
   byte_t wr_data;
   logic  tx_full;
   logic  rd;
   byte_t rd_data;
   logic  rx_empty;
   logic  tx;
   logic  rx_line;
   logic  loop_en;   // low cuts the loop, rx then follows rx_hold
   logic  rx_hold;

   assign rx_line = loop_en ? tx : rx_hold;

   uart_top #(.baud_div(baud_div), .fifo_adr_width(adr_width)) i_uart_top
   (
      .clk(clk), .reset(reset),
      .wr(wr), .wr_data(wr_data), .tx_full(tx_full),
      .rd(rd), .rd_data(rd_data), .rx_empty(rx_empty),
      .rx(rx_line), .tx(tx)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic stop_on_failure();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
      if (actual !== expected)
      begin
         $display("** Error: %s expected %h, got %h", name, expected, actual);
         stop_on_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("** Error: %s expected %h, got %h", name, expected, actual);
         stop_on_failure();
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual != expected)
      begin
         $display("** Error: %s expected %h, got %h", name, expected, actual);
         stop_on_failure();
      end
   endtask

   // called on a falling edge, returns on the next one
   task automatic drive_write(input byte_t b, output bit accepted);
      accepted = !tx_full;  // full is stable until the write edge
      wr       = 1'b1;
      wr_data  = b;
      @(negedge clk);
      wr = 1'b0;
   endtask

   task automatic pop_byte(output byte_t b);
      while (rx_empty)
         @(negedge clk);
      b  = rd_data;
      rd = 1'b1;
      @(negedge clk);
      rd = 1'b0;
   endtask

   // longer high than any frame can hold, so the transmitter has drained
   task automatic wait_line_idle();
      int high_cycles;
      high_cycles = 0;
      while (high_cycles < 11 * bit_cycles)
      begin
         @(negedge clk);
         if (tx)
            high_cycles++;
         else
            high_cycles = 0;
      end
   endtask

   task automatic test_reset_state();
      check_flag("tx", 1'b1, tx);
      check_flag("rx_empty", 1'b1, rx_empty);
      check_flag("tx_full", 1'b0, tx_full);
   endtask

   task automatic test_single_byte();
      byte_t b;
      byte_t got;
      bit    acc;
      b = byte_t'($urandom);
      drive_write(b, acc);
      check_flag("write accepted", 1'b1, acc);
      pop_byte(got);
      check_byte("rd_data", b, got);
      check_flag("rx_empty", 1'b1, rx_empty);
   endtask

   task automatic test_fifo_order();
      byte_t q[$];
      byte_t b;
      bit    acc;
      for (int i = 0; i < 12; i++)
      begin
         b = byte_t'($urandom);
         drive_write(b, acc);
         check_flag("write accepted", 1'b1, acc);
         q.push_back(b);
      end
      while (q.size() > 0)
      begin
         pop_byte(b);
         check_byte("rd_data", q.pop_front(), b);
      end
   endtask

   task automatic test_tx_full();
      byte_t q[$];
      byte_t b;
      bit    acc;
      int    accepted;
      int    received;
      accepted = 0;
      received = 0;
      wait_line_idle();  // transmitter free to take the first byte at once
      loop_en  = 1'b0;
      rx_hold  = 1'b1;
      for (int i = 0; i < depth + 4; i++)
      begin
         b = byte_t'($urandom);
         drive_write(b, acc);
         if (acc)
         begin
            q.push_back(b);
            accepted++;
         end
         if (i == depth)
            check_flag("tx_full", 1'b1, tx_full);  // one in the shifter, depth waiting
      end
      check_count("accepted writes", depth + 1, accepted);
      // full drops when the second frame starts, its start bit is low right now
      while (tx_full)
         @(negedge clk);
      loop_en = 1'b1;
      void'(q.pop_front());  // sent while the loop was cut
      while (q.size() > 0)
      begin
         pop_byte(b);
         check_byte("rd_data", q.pop_front(), b);
         received++;
      end
      wait_line_idle();
      while (!rx_empty)
      begin
         pop_byte(b);
         received++;  // only a refused write could land here
      end
      check_count("received bytes", accepted - 1, received);
   endtask

   task automatic test_rx_overflow();
      byte_t q[$];
      byte_t b;
      bit    acc;
      for (int i = 0; i < 20; i++)
      begin
         b = byte_t'($urandom);
         do
         begin
            drive_write(b, acc);  // refused while full, so offer it again
         end
         while (!acc);
         if (i < depth)
            q.push_back(b);
      end
      wait_line_idle();
      for (int i = 0; i < depth; i++)
      begin
         check_flag("rx_empty", 1'b0, rx_empty);
         pop_byte(b);
         check_byte("rd_data", q.pop_front(), b);
      end
      check_flag("rx_empty", 1'b1, rx_empty);
   endtask

   task automatic test_glitch();
      loop_en = 1'b0;
      rx_hold = 1'b0;
      repeat (8) @(negedge clk);  // half a bit is 32 clocks
      rx_hold = 1'b1;
      repeat (frame_cycles) @(negedge clk);
      check_flag("rx_empty", 1'b1, rx_empty);
      loop_en = 1'b1;
   endtask

   initial
   begin
      #(watchdog_ns);
      $display("timeout waiting for receive data");
      stop_on_failure();
   end

   initial
   begin
      void'($urandom(32'h5324_68bd));
      reset   = 1'b1;
      wr      = 1'b0;
      wr_data = '0;
      rd      = 1'b0;
      loop_en = 1'b1;
      rx_hold = 1'b1;
      repeat (16) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      test_reset_state();
      test_single_byte();
      test_fifo_order();
      test_tx_full();
      test_rx_overflow();
      test_glitch();

      $display("All tests passed!");
      $finish;
   end

endmodule

/* rtl/uart_top.sv */
/* byte-wide serial port
   host write and read ports buffered by a transmit and a receive fifo */
module uart_top
#(
   parameter int baud_div       = 4,
   parameter int fifo_adr_width = 4
)
(
   input  logic           clk,
   input  logic           reset,
   input  logic           wr,
   input  uart_pkg::byte_t wr_data,
   output logic           tx_full,
   input  logic           rd,
   output uart_pkg::byte_t rd_data,
   output logic           rx_empty,
   input  logic           rx,
   output logic           tx
);

   logic tick;

   fifo_if tx_fifo_bus ();
   fifo_if rx_fifo_bus ();

   // host is the producer of the transmit fifo
   assign tx_fifo_bus.wr    = wr;
   assign tx_fifo_bus.wdata = wr_data;
   assign tx_full           = tx_fifo_bus.full;

   // and the consumer of the receive fifo
   assign rx_fifo_bus.rd = rd;
   assign rd_data        = rx_fifo_bus.rdata;
   assign rx_empty       = rx_fifo_bus.empty;

   baud_gen #(.baud_div(baud_div)) i_baud_gen
   (
      .clk(clk), .reset(reset), .tick(tick)
   );

   fifo #(.adr_width(fifo_adr_width)) i_tx_fifo
   (
      .clk(clk), .reset(reset), .bus(tx_fifo_bus.storage)
   );

   fifo #(.adr_width(fifo_adr_width)) i_rx_fifo
   (
      .clk(clk), .reset(reset), .bus(rx_fifo_bus.storage)
   );

   uart_tx i_uart_tx
   (
      .clk(clk), .reset(reset), .tick(tick), .tx(tx), .bus(tx_fifo_bus.consumer)
   );

   uart_rx i_uart_rx
   (
      .clk(clk), .reset(reset), .tick(tick), .rx(rx), .bus(rx_fifo_bus.producer)
   );

endmodule

/* rtl/uart_tx.sv */
/* serial transmitter
   pulls one byte per frame from the transmit fifo and sends it 8n1, lsb first */
module uart_tx
(
   input  logic      clk,
   input  logic      reset,
   input  logic      tick,
   output logic      tx,
   fifo_if.consumer  bus
);
   import uart_pkg::*;

   tx_state_t state;
   tick_cnt_t tick_cnt;
   logic [2:0] bit_cnt;
   byte_t     shift_reg;
   logic      tx_reg;
   logic      bit_end;
   logic      load;

   assign bit_end = tick && (tick_cnt == 4'd15);

   // fetch from idle, or right at the end of a stop bit for back to back frames
   assign load = tick && !bus.empty &&
                 ((state == tx_idle) || (state == tx_stop && tick_cnt == 4'd15));

   assign bus.rd = load;
   assign tx     = tx_reg;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state    <= tx_idle;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         tx_reg   <= 1'b1;  // line idles high
      end
      else
      begin
         case (state)
            tx_idle:
               if (load)
               begin
                  state    <= tx_start;
                  tick_cnt <= '0;
                  tx_reg   <= 1'b0;
               end
            tx_start:
               if (tick)
               begin
                  tick_cnt <= tick_cnt + 1'b1;
                  if (bit_end)
                  begin
                     state   <= tx_data;
                     bit_cnt <= '0;
                     tx_reg  <= shift_reg[0];
                  end
               end
            tx_data:
               if (tick)
               begin
                  tick_cnt <= tick_cnt + 1'b1;
                  if (bit_end)
                  begin
                     if (bit_cnt == 3'd7)
                     begin
                        state  <= tx_stop;
                        tx_reg <= 1'b1;
                     end
                     else
                     begin
                        bit_cnt <= bit_cnt + 1'b1;
                        tx_reg  <= shift_reg[1];  // next bit after the shift
                     end
                  end
               end
            tx_stop:
               if (tick)
               begin
                  tick_cnt <= tick_cnt + 1'b1;
                  if (load)
                  begin
                     state  <= tx_start;
                     tx_reg <= 1'b0;
                  end
                  else if (bit_end)
                     state <= tx_idle;
               end
            default: state <= tx_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
         shift_reg <= bus.rdata;
      else if (state == tx_data && bit_end)
         shift_reg <= shift_reg >> 1;
   end

   // no frame in flight means the line rests high
   a_idle_high: assert property (@(posedge clk) disable iff (reset)
      (state == tx_idle) |-> tx)
      else $error("transmit line low while idle");

endmodule

/* rtl/uart_rx.sv */
/* serial receiver, 16x oversampled
   rebuilds 8n1 frames lsb first and writes each byte to the receive fifo */
module uart_rx
(
   input logic       clk,
   input logic       reset,
   input logic       tick,
   input logic       rx,
   fifo_if.producer  bus
);
   import uart_pkg::*;

   rx_state_t state;
   tick_cnt_t tick_cnt;
   logic [2:0] bit_cnt;
   byte_t     shift_reg;
   logic [1:0] rx_sync;
   logic      rx_s;
   logic      sample;
   logic      wr_reg;

   assign rx_s   = rx_sync[1];
   assign sample = tick && (tick_cnt == 4'd15);  // mid-bit once aligned

   assign bus.wr    = wr_reg;
   assign bus.wdata = shift_reg;

   // two-flop synchronizer, line idles high
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         rx_sync <= 2'b11;
      else
         rx_sync <= {rx_sync[0], rx};
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state    <= rx_idle;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         wr_reg   <= 1'b0;
      end
      else
      begin
         // one pulse at the stop sample, fifo drops it if full
         wr_reg <= (state == rx_stop) && sample;
         case (state)
            rx_idle:
               if (tick && !rx_s)
               begin
                  state    <= rx_start;
                  tick_cnt <= '0;
               end
            rx_start:
               if (tick)
               begin
                  tick_cnt <= tick_cnt + 1'b1;
                  if (tick_cnt == 4'd7)
                  begin
                     if (rx_s)
                        state <= rx_idle;  // glitch, not a start bit
                     else
                     begin
                        state    <= rx_data;
                        tick_cnt <= '0;    // realign on mid-bit
                        bit_cnt  <= '0;
                     end
                  end
               end
            rx_data:
               if (tick)
               begin
                  tick_cnt <= tick_cnt + 1'b1;
                  if (sample)
                  begin
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == 3'd7)
                        state <= rx_stop;
                  end
               end
            rx_stop:
               if (tick)
               begin
                  tick_cnt <= tick_cnt + 1'b1;
                  if (sample)
                     state <= rx_idle;
               end
            default: state <= rx_idle;
         endcase
      end
   end

   // lsb arrives first
   always_ff @(posedge clk)
   begin
      if (state == rx_data && sample)
         shift_reg <= {rx_s, shift_reg[7:1]};
   end

   a_wr_pulse: assert property (@(posedge clk) disable iff (reset)
      bus.wr |=> !bus.wr)
      else $error("receive fifo write longer than one cycle");

endmodule

/* rtl/baud_gen.sv */
/* oversampling tick divider
   one-cycle tick every baud_div clocks, 16 ticks per bit */
module baud_gen
#(
   parameter int baud_div = 4
)
(
   input  logic clk,
   input  logic reset,
   output logic tick
);

   localparam int cnt_width = (baud_div > 1) ? $clog2(baud_div) : 1;

   logic [cnt_width-1:0] cnt;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         cnt  <= cnt_width'(baud_div - 1);
         tick <= 1'b0;
      end
      else
      begin
         tick <= (cnt == '0);
         if (cnt == '0)
            cnt <= cnt_width'(baud_div - 1);  // reload
         else
            cnt <= cnt - 1'b1;
      end
   end

   a_tick_single: assert property (@(posedge clk) disable iff (reset)
      tick |=> (!tick || baud_div == 1))
      else $error("tick held for more than one cycle");

endmodule

/* rtl/fifo.sv */
/* circular buffer fifo of bytes
   registered full and empty flags, refused write when full, refused read when empty */
module fifo
#(
   parameter int adr_width = 4
)
(
   input logic      clk,
   input logic      reset,
   fifo_if.storage  bus
);
   import uart_pkg::*;

   localparam int depth = 1 << adr_width;

   byte_t mem [depth];

   logic [adr_width-1:0] w_ptr, w_ptr_next;
   logic [adr_width-1:0] r_ptr, r_ptr_next;
   logic full_reg, full_next;
   logic empty_reg, empty_next;
   logic wr_en, rd_en;

   // refused operations are dropped here, also when both pulses come together
   assign wr_en = bus.wr & ~full_reg;
   assign rd_en = bus.rd & ~empty_reg;

   assign bus.rdata = mem[r_ptr];  // head shown combinationally
   assign bus.full  = full_reg;
   assign bus.empty = empty_reg;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[w_ptr] <= bus.wdata;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         w_ptr     <= '0;
         r_ptr     <= '0;
         full_reg  <= 1'b0;
         empty_reg <= 1'b1;
      end
      else
      begin
         w_ptr     <= w_ptr_next;
         r_ptr     <= r_ptr_next;
         full_reg  <= full_next;
         empty_reg <= empty_next;
      end
   end

   always_comb
   begin
      w_ptr_next = w_ptr;
      r_ptr_next = r_ptr;
      full_next  = full_reg;
      empty_next = empty_reg;
      case ({wr_en, rd_en})
         2'b01:
         begin
            r_ptr_next = r_ptr + 1'b1;
            full_next  = 1'b0;
            empty_next = (r_ptr_next == w_ptr);
         end
         2'b10:
         begin
            w_ptr_next = w_ptr + 1'b1;
            empty_next = 1'b0;
            full_next  = (w_ptr_next == r_ptr);
         end
         2'b11:
         begin
            // neither full nor empty here, so the flags hold
            w_ptr_next = w_ptr + 1'b1;
            r_ptr_next = r_ptr + 1'b1;
         end
         default: ;
      endcase
   end

   a_flags_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(full_reg && empty_reg))
      else $error("fifo full and empty at once");

   a_flags_ptrs: assert property (@(posedge clk) disable iff (reset)
      (full_reg || empty_reg) |-> (w_ptr == r_ptr))
      else $error("fifo flag set with pointers apart");

endmodule

/* rtl/fifo_if.sv */
/* fifo bus
   write side, read side and the full/empty flags of one byte fifo */
interface fifo_if;
   import uart_pkg::*;

   logic  wr;     // write request
   byte_t wdata;
   logic  full;
   logic  rd;     // read request, pops the head
   byte_t rdata;  // head entry
   logic  empty;

   modport producer
   (
      output wr, wdata,
      input  full
   );

   modport consumer
   (
      output rd,
      input  rdata, empty
   );

   // fifo side, mirror of the two above
   modport storage
   (
      input  wr, wdata, rd,
      output full, rdata, empty
   );

endinterface

/* rtl/uart_pkg.sv */
/* uart shared types
   byte and tick counter widths, receiver and transmitter state encodings */
package uart_pkg;

   // one data byte through the fifos and on the host ports
   typedef logic [7:0] byte_t;

   // oversampling ticks within one bit period, 16 per bit
   typedef logic [3:0] tick_cnt_t;

   typedef enum logic [1:0]
   {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_t;

   typedef enum logic [1:0]
   {
      tx_idle,
      tx_start,
      tx_data,
      tx_stop
   } tx_state_t;

endpackage
